/* filelist.f */
lab_pkg.sv
lab_alu_unit.sv
lfsr_gen.sv
ps2_receiver.sv
wb_arbiter.sv
seg_display_regs.sv
lab_top.sv
tb_lab_asserts.sv
tb_lab_top.sv

/* lab_alu_unit.sv */
`timescale 1ns/100ps

module lab_alu_unit (
    input  logic             btn,
    input  logic             arst_n,
    input  logic [15:0]      sw,
    output lab_pkg::wb_req_t bus_req,
    input  lab_pkg::wb_rsp_t bus_rsp
);
    import lab_pkg::*;

    logic [10:0] sw_q;
    logic        dirty;
    logic        start;
    logic [3:0]  a;
    logic [3:0]  b;
    alu_op_e     op;
    logic [4:0]  wide;
    logic [3:0]  res;
    logic        carry;
    logic        ovf;
    logic        zero;

    assign a  = sw_q[3:0];
    assign b  = sw_q[7:4];
    assign op = alu_op_e'(sw_q[10:8]);

    always_comb begin
        wide  = '0;
        res   = '0;
        carry = 1'b0;
        ovf   = 1'b0;
        case (op)
            op_add: begin
                wide  = {1'b0, a} + {1'b0, b};
                res   = wide[3:0];
                carry = wide[4];
                ovf   = (a[3] == b[3]) && (res[3] != a[3]);
            end
            op_sub: begin
                // bit 4 is the borrow here
                wide  = {1'b0, a} - {1'b0, b};
                res   = wide[3:0];
                carry = wide[4];
                ovf   = (a[3] != b[3]) && (res[3] != a[3]);
            end
            op_not: res = ~a;
            op_and: res = a & b;
            op_or:  res = a | b;
            op_xor: res = a ^ b;
            op_slt: res = {3'b000, $signed(a) < $signed(b)};
            op_eq:  res = {3'b000, a == b};
            default: res = '0;
        endcase
    end

    assign zero  = (res == 4'h0);
    assign start = dirty && !bus_req.cyc;

    always_ff @(posedge btn or negedge arst_n) begin
        if (!arst_n) begin
            sw_q    <= '0;
            dirty   <= 1'b1;
            bus_req <= '0;
        end else begin
            sw_q  <= sw[10:0];
            dirty <= (sw[10:0] != sw_q) || (dirty && !start);
            if (start) begin
                bus_req <= '{cyc: 1'b1, stb: 1'b1, we: 1'b1, adr: addr_alu,
                             dat: {9'd0, carry, ovf, zero, res}};
            end else if (bus_rsp.ack) begin
                bus_req.cyc <= 1'b0;
                bus_req.stb <= 1'b0;
            end
        end
    end

endmodule

/* lab_pkg.sv */
package lab_pkg;

    typedef enum logic [2:0] {
        op_add,
        op_sub,
        op_not,
        op_and,
        op_or,
        op_xor,
        op_slt,
        op_eq
    } alu_op_e;

    typedef enum logic [1:0] {
        addr_key   = 2'd0,
        addr_rand  = 2'd1,
        addr_alu   = 2'd2,
        addr_count = 2'd3
    } reg_addr_e;

    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;
        logic [1:0]  adr;
        logic [15:0] dat;
    } wb_req_t;

    typedef struct packed {
        logic        ack;
        logic [15:0] dat;
    } wb_rsp_t;

    // active low, bit 7 is the point, bits 6:0 are g..a
    typedef struct packed {
        logic [7:0] dig7;
        logic [7:0] dig6;
        logic [7:0] dig5;
        logic [7:0] dig4;
        logic [7:0] dig3;
        logic [7:0] dig2;
        logic [7:0] dig1;
        logic [7:0] dig0;
    } seg_bank_t;

    function automatic logic [7:0] hex_to_seg(input logic [3:0] hex);
        logic [7:0] pattern;
        case (hex)
            4'h0: pattern = 8'hC0;
            4'h1: pattern = 8'hF9;
            4'h2: pattern = 8'hA4;
            4'h3: pattern = 8'hB0;
            4'h4: pattern = 8'h99;
            4'h5: pattern = 8'h92;
            4'h6: pattern = 8'h82;
            4'h7: pattern = 8'hF8;
            4'h8: pattern = 8'h80;
            4'h9: pattern = 8'h90;
            4'hA: pattern = 8'h88;
            4'hB: pattern = 8'h83;
            4'hC: pattern = 8'hC6;
            4'hD: pattern = 8'hA1;
            4'hE: pattern = 8'h86;
            default: pattern = 8'h8E;
        endcase
        return pattern;
    endfunction

endpackage

/* lab_top.sv */
`timescale 1ns/100ps

module lab_top #(
    parameter int num_masters = 3
) (
    input  logic               btn,
    input  logic               arst_n,
    input  logic [15:0]        sw,
    input  logic               step,
    input  logic               ps2_clk,
    input  logic               ps2_data,
    output lab_pkg::seg_bank_t seg,
    output logic [15:0]        ledr
);
    import lab_pkg::*;

    wb_req_t     m_req [num_masters];
    wb_rsp_t     m_rsp [num_masters];
    wb_req_t     s_req;
    wb_rsp_t     s_rsp;
    logic        parity_err;
    logic [15:0] disp_ledr;

    // master 0 alu, 1 lfsr, 2 keyboard
    lab_alu_unit alu_i (
        .btn     (btn),
        .arst_n  (arst_n),
        .sw      (sw),
        .bus_req (m_req[0]),
        .bus_rsp (m_rsp[0])
    );

    lfsr_gen lfsr_i (
        .btn     (btn),
        .arst_n  (arst_n),
        .step    (step),
        .bus_req (m_req[1]),
        .bus_rsp (m_rsp[1])
    );

    ps2_receiver ps2_i (
        .btn        (btn),
        .arst_n     (arst_n),
        .ps2_clk    (ps2_clk),
        .ps2_data   (ps2_data),
        .parity_err (parity_err),
        .bus_req    (m_req[2]),
        .bus_rsp    (m_rsp[2])
    );

    // spare arbiter ports stay quiet
    for (genvar i = 3; i < num_masters; i++) begin : g_spare
        assign m_req[i] = '0;
    end

    wb_arbiter #(
        .num_masters (num_masters)
    ) arb_i (
        .btn    (btn),
        .arst_n (arst_n),
        .m_req  (m_req),
        .m_rsp  (m_rsp),
        .s_req  (s_req),
        .s_rsp  (s_rsp)
    );

    seg_display_regs disp_i (
        .btn     (btn),
        .arst_n  (arst_n),
        .bus_req (s_req),
        .bus_rsp (s_rsp),
        .seg     (seg),
        .ledr    (disp_ledr)
    );

    assign ledr = {disp_ledr[15:4], parity_err, disp_ledr[2:0]};

endmodule

/* lfsr_gen.sv */
`timescale 1ns/100ps

module lfsr_gen (
    input  logic             btn,
    input  logic             arst_n,
    input  logic             step,
    output lab_pkg::wb_req_t bus_req,
    input  lab_pkg::wb_rsp_t bus_rsp
);
    import lab_pkg::*;

    logic [7:0] value_q;
    logic [7:0] next_value;
    logic       pending;
    logic       start;

    // taps 4, 3, 2, 0 feed bit 7; all zero would lock up
    assign next_value = (value_q == 8'h00) ? 8'h01
                      : {value_q[4] ^ value_q[3] ^ value_q[2] ^ value_q[0], value_q[7:1]};

    assign start = pending && !bus_req.cyc;

    always_ff @(posedge btn or negedge arst_n) begin
        if (!arst_n) begin
            value_q <= 8'h01;
            pending <= 1'b0;
            bus_req <= '0;
        end else begin
            if (step) begin
                value_q <= next_value;
            end
            // steps during a write merge into the next one
            pending <= step || (pending && !start);
            if (start) begin
                bus_req <= '{cyc: 1'b1, stb: 1'b1, we: 1'b1, adr: addr_rand,
                             dat: {8'h00, value_q}};
            end else if (bus_rsp.ack) begin
                bus_req.cyc <= 1'b0;
                bus_req.stb <= 1'b0;
            end
        end
    end

endmodule

/* ps2_receiver.sv */
`timescale 1ns/100ps

module ps2_receiver (
    input  logic             btn,
    input  logic             arst_n,
    input  logic             ps2_clk,
    input  logic             ps2_data,
    output logic             parity_err,
    output lab_pkg::wb_req_t bus_req,
    input  lab_pkg::wb_rsp_t bus_rsp
);
    import lab_pkg::*;

    typedef enum logic [1:0] {
        st_idle,
        st_data,
        st_parity,
        st_stop
    } rx_state_e;

    rx_state_e  state;
    logic [2:0] clk_sync;
    logic [1:0] data_sync;
    logic       fall;
    logic       rx_bit;
    logic [2:0] bit_cnt;
    logic       parity_ok;
    logic       good_stop;
    logic [7:0] shift_q;
    logic [7:0] code_q;
    logic [7:0] count_q;
    logic       pend_code;
    logic       pend_count;
    logic       start_code;
    logic       start_count;

    // bit 2 only keeps the previous level for edge detection
    assign fall   = clk_sync[2] && !clk_sync[1];
    assign rx_bit = data_sync[1];

    assign good_stop   = fall && (state == st_stop) && rx_bit && parity_ok;
    assign start_code  = pend_code && !bus_req.cyc;
    assign start_count = pend_count && !pend_code && !bus_req.cyc;

    always_ff @(posedge btn) begin
        if (fall && state == st_data) begin
            shift_q <= {rx_bit, shift_q[7:1]};
        end
        if (good_stop) begin
            code_q <= shift_q;
        end
    end

    always_ff @(posedge btn or negedge arst_n) begin
        if (!arst_n) begin
            clk_sync   <= '1;
            data_sync  <= '1;
            state      <= st_idle;
            bit_cnt    <= '0;
            parity_ok  <= 1'b0;
            parity_err <= 1'b0;
            count_q    <= '0;
            pend_code  <= 1'b0;
            pend_count <= 1'b0;
            bus_req    <= '0;
        end else begin
            clk_sync  <= {clk_sync[1:0], ps2_clk};
            data_sync <= {data_sync[0], ps2_data};
            if (fall) begin
                case (state)
                    st_idle: begin
                        if (!rx_bit) begin
                            state   <= st_data;
                            bit_cnt <= '0;
                        end
                    end
                    st_data: begin
                        bit_cnt <= bit_cnt + 3'd1;
                        if (bit_cnt == 3'd7) state <= st_parity;
                    end
                    st_parity: begin
                        // odd parity over data and parity bit
                        parity_ok <= ^{rx_bit, shift_q};
                        state     <= st_stop;
                    end
                    default: begin
                        state <= st_idle;
                        if (!parity_ok) parity_err <= 1'b1;
                    end
                endcase
            end
            if (good_stop) count_q <= count_q + 8'd1;
            pend_code  <= good_stop || (pend_code && !start_code);
            pend_count <= good_stop || (pend_count && !start_count);
            if (start_code) begin
                bus_req <= '{cyc: 1'b1, stb: 1'b1, we: 1'b1, adr: addr_key,
                             dat: {8'h00, code_q}};
            end else if (start_count) begin
                bus_req <= '{cyc: 1'b1, stb: 1'b1, we: 1'b1, adr: addr_count,
                             dat: {8'h00, count_q}};
            end else if (bus_rsp.ack) begin
                bus_req.cyc <= 1'b0;
                bus_req.stb <= 1'b0;
            end
        end
    end

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the lab testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_lab_top \
    -f filelist.f \
    -o sim_tb_lab_top

./obj_dir/sim_tb_lab_top | tee sim.log

grep -q ">>> PASS" sim.log

/* seg_display_regs.sv */
`timescale 1ns/100ps

module seg_display_regs (
    input  logic               btn,
    input  logic               arst_n,
    input  lab_pkg::wb_req_t   bus_req,
    output lab_pkg::wb_rsp_t   bus_rsp,
    output lab_pkg::seg_bank_t seg,
    output logic [15:0]        ledr
);
    import lab_pkg::*;

    logic        ack_q;
    logic        wr_en;
    logic [3:0]  written_q;
    logic [7:0]  key_q;
    logic [7:0]  rand_q;
    logic [6:0]  alu_q;
    logic [7:0]  count_q;
    seg_bank_t   seg_next;
    logic [15:0] ledr_next;

    // the ack cycle is not a second access
    assign wr_en   = bus_req.cyc && bus_req.stb && bus_req.we && !ack_q;
    assign bus_rsp = '{ack: ack_q, dat: 16'h0000};

    always_ff @(posedge btn) begin
        if (wr_en) begin
            case (reg_addr_e'(bus_req.adr))
                addr_key:   key_q   <= bus_req.dat[7:0];
                addr_rand:  rand_q  <= bus_req.dat[7:0];
                addr_alu:   alu_q   <= bus_req.dat[6:0];
                addr_count: count_q <= bus_req.dat[7:0];
            endcase
        end
    end

    always_comb begin
        seg_next  = '1;
        ledr_next = '0;
        if (written_q[addr_key]) begin
            seg_next.dig0 = hex_to_seg(key_q[3:0]);
            seg_next.dig1 = hex_to_seg(key_q[7:4]);
        end
        if (written_q[addr_rand]) begin
            seg_next.dig2   = hex_to_seg(rand_q[3:0]);
            seg_next.dig3   = hex_to_seg(rand_q[7:4]);
            ledr_next[15:8] = rand_q;
        end
        if (written_q[addr_alu]) begin
            seg_next.dig4  = hex_to_seg(alu_q[3:0]);
            ledr_next[2:0] = alu_q[6:4];
        end
        if (written_q[addr_count]) begin
            seg_next.dig6 = hex_to_seg(count_q[3:0]);
            seg_next.dig7 = hex_to_seg(count_q[7:4]);
        end
    end

    always_ff @(posedge btn or negedge arst_n) begin
        if (!arst_n) begin
            ack_q     <= 1'b0;
            written_q <= '0;
            seg       <= '1;
            ledr      <= '0;
        end else begin
            ack_q <= bus_req.cyc && bus_req.stb && !ack_q;
            if (wr_en) written_q[bus_req.adr] <= 1'b1;
            seg  <= seg_next;
            ledr <= ledr_next;
        end
    end

endmodule

/* tb_lab_asserts.sv */
`timescale 1ns/100ps

module tb_lab_asserts #(
    parameter int num_masters = 3
) (
    input logic                   btn,
    input logic                   arst_n,
    input logic [num_masters-1:0] grant,
    input lab_pkg::wb_req_t       s_req,
    input lab_pkg::wb_rsp_t       s_rsp
);

    // one owner keeps the grant until its ack
    grant_locked: assert property (@(posedge btn) disable iff (!arst_n)
        s_req.cyc && !s_rsp.ack |=> $onehot(grant) && $stable(grant))
        else $error("grant moved to another master while a cycle was pending");

    // the acked access is gone on the next cycle
    ack_single: assert property (@(posedge btn) disable iff (!arst_n)
        s_rsp.ack |=> !s_rsp.ack && !(s_req.stb && $stable(s_req.adr)))
        else $error("ack lasted longer than one cycle or the access was not released");

    stb_held: assert property (@(posedge btn) disable iff (!arst_n)
        s_req.stb && !s_rsp.ack |=> s_req.stb)
        else $error("stb dropped before ack");

    // a pending write keeps its address and data
    req_stable: assert property (@(posedge btn) disable iff (!arst_n)
        s_req.stb && !s_rsp.ack |=> $stable(s_req.adr) && $stable(s_req.dat))
        else $error("adr or dat changed while a cycle was pending");

endmodule

bind wb_arbiter tb_lab_asserts #(.num_masters(num_masters)) asserts_i (
    .btn    (btn),
    .arst_n (arst_n),
    .grant  (grant),
    .s_req  (s_req),
    .s_rsp  (s_rsp)
);

/* tb_lab_top.sv */
`timescale 1ns/100ps

module tb_lab_top;
    import lab_pkg::*;

    localparam int half_bit      = 10;
    localparam int idle_run      = 12;
    localparam int settle_cycles = 60;
    localparam int frame_cycles  = 22 * half_bit + 30;
    // summed length of all tests in clock cycles
    localparam int test_cycles   = 10 + settle_cycles
                                 + 20 * (settle_cycles + 2)
                                 + 12 * 10 + settle_cycles
                                 + 3 * (frame_cycles + settle_cycles)
                                 + frame_cycles + settle_cycles
                                 + frame_cycles + 260 + settle_cycles;
    localparam int watchdog_cycles = 2 * test_cycles + 500;

    logic        btn;
    logic        arst_n;
    logic [15:0] sw;
    logic        step;
    logic        ps2_clk;
    logic        ps2_data;
    seg_bank_t   seg;
    logic [15:0] ledr;

    logic [15:0] rng_state;
    int          seg_errors;
    int          led_errors;
    int          other_errors;

    // reference model state
    logic [7:0]  exp_key;
    logic [7:0]  exp_rand;
    logic [6:0]  exp_alu;
    logic [7:0]  exp_count;
    logic        exp_perr;
    logic        key_seen;
    logic        rand_seen;

    lab_top #(
        .num_masters (3)
    ) lab_top_i (
        .btn      (btn),
        .arst_n   (arst_n),
        .sw       (sw),
        .step     (step),
        .ps2_clk  (ps2_clk),
        .ps2_data (ps2_data),
        .seg      (seg),
        .ledr     (ledr)
    );

    always #5 btn = ~btn;

    // segments lit for each hex digit, g..a, active high
    function automatic logic [7:0] digit_image(input logic [3:0] hex);
        logic [6:0] lit;
        case (hex)
            4'h0: lit = 7'h3F;
            4'h1: lit = 7'h06;
            4'h2: lit = 7'h5B;
            4'h3: lit = 7'h4F;
            4'h4: lit = 7'h66;
            4'h5: lit = 7'h6D;
            4'h6: lit = 7'h7D;
            4'h7: lit = 7'h07;
            4'h8: lit = 7'h7F;
            4'h9: lit = 7'h6F;
            4'hA: lit = 7'h77;
            4'hB: lit = 7'h7C;
            4'hC: lit = 7'h39;
            4'hD: lit = 7'h5E;
            4'hE: lit = 7'h79;
            default: lit = 7'h71;
        endcase
        return {1'b1, ~lit};
    endfunction

    // returns carry, overflow, zero and the four-bit result
    function automatic logic [6:0] alu_model(input logic [3:0] a, input logic [3:0] b,
                                             input alu_op_e op);
        int         ua;
        int         ub;
        int         sa;
        int         sb;
        int         r;
        int         sr;
        logic       carry;
        logic       ovf;
        logic [3:0] res;
        ua    = int'(a);
        ub    = int'(b);
        sa    = (ua > 7) ? ua - 16 : ua;
        sb    = (ub > 7) ? ub - 16 : ub;
        sr    = 0;
        carry = 1'b0;
        ovf   = 1'b0;
        case (op)
            op_add: begin
                r     = ua + ub;
                sr    = sa + sb;
                carry = (r > 15);
                ovf   = (sr > 7) || (sr < -8);
            end
            op_sub: begin
                r     = ua - ub;
                sr    = sa - sb;
                carry = (ua < ub);
                ovf   = (sr > 7) || (sr < -8);
            end
            op_not: r = 15 - ua;
            op_and: r = int'(a & b);
            op_or:  r = int'(a | b);
            op_xor: r = int'(a ^ b);
            op_slt: r = (sa < sb) ? 1 : 0;
            default: r = (ua == ub) ? 1 : 0;
        endcase
        res = r[3:0];
        return {carry, ovf, res == 4'h0, res};
    endfunction

    function automatic logic [7:0] lfsr_model_step(input logic [7:0] v);
        if (v == 8'h00) begin
            return 8'h01;
        end
        return {v[4] ^ v[3] ^ v[2] ^ v[0], v[7:1]};
    endfunction

    // 16 bit fibonacci, taps 16 14 13 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic draw_bits(input int n, output logic [15:0] val);
        val = '0;
        for (int i = 0; i < n; i++) begin
            rng_state = lfsr_next(rng_state);
            val       = {val[14:0], rng_state[0]};
        end
    endtask

    function automatic seg_bank_t expected_seg();
        seg_bank_t s;
        s      = '1;
        s.dig4 = digit_image(exp_alu[3:0]);
        if (key_seen) begin
            s.dig0 = digit_image(exp_key[3:0]);
            s.dig1 = digit_image(exp_key[7:4]);
            s.dig6 = digit_image(exp_count[3:0]);
            s.dig7 = digit_image(exp_count[7:4]);
        end
        if (rand_seen) begin
            s.dig2 = digit_image(exp_rand[3:0]);
            s.dig3 = digit_image(exp_rand[7:4]);
        end
        return s;
    endfunction

    function automatic logic [15:0] expected_leds();
        logic [7:0] r;
        r = rand_seen ? exp_rand : 8'h00;
        return {r, 4'h0, exp_perr, exp_alu[6:4]};
    endfunction

    task automatic check_seg(input string name, input seg_bank_t exp, input seg_bank_t act);
        if (act !== exp) begin
            seg_errors++;
            $display("[ERROR] %s seg: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_leds(input string name, input logic [15:0] exp,
                              input logic [15:0] act);
        if (act !== exp) begin
            led_errors++;
            $display("[ERROR] %s ledr: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_display(input string name);
        check_seg(name, expected_seg(), seg);
        check_leds(name, expected_leds(), ledr);
    endtask

    task automatic wait_bus_idle(input string name);
        int quiet;
        int waited;
        quiet  = 0;
        waited = 0;
        while (quiet < idle_run && waited < settle_cycles * 10) begin
            @(negedge btn);
            waited++;
            if (lab_top_i.s_req.cyc) begin
                quiet = 0;
            end else begin
                quiet++;
            end
        end
        if (quiet < idle_run) begin
            other_errors++;
            $display("%s: the bus never went idle", name);
        end
    endtask

    task automatic send_frame(input logic [7:0] code, input logic bad_parity);
        logic [10:0] frame;
        // stop, odd parity, data lsb first, start
        frame = {1'b1, (~^code) ^ bad_parity, code, 1'b0};
        @(negedge btn);
        for (int i = 0; i < 11; i++) begin
            ps2_data = frame[i];
            repeat (half_bit) @(negedge btn);
            ps2_clk = 1'b0;
            repeat (half_bit) @(negedge btn);
            ps2_clk = 1'b1;
        end
        ps2_data = 1'b1;
    endtask

    task automatic send_good_key(input logic [7:0] code);
        send_frame(code, 1'b0);
        exp_key   = code;
        exp_count = exp_count + 8'd1;
        key_seen  = 1'b1;
    endtask

    // n back to back step cycles
    task automatic step_burst(input int n);
        @(negedge btn);
        step = 1'b1;
        repeat (n) @(negedge btn);
        step = 1'b0;
        for (int i = 0; i < n; i++) begin
            exp_rand = lfsr_model_step(exp_rand);
        end
        rand_seen = 1'b1;
    endtask

    task automatic apply_random_sw();
        logic [15:0] a;
        logic [15:0] b;
        logic [15:0] op;
        draw_bits(4, a);
        draw_bits(4, b);
        draw_bits(3, op);
        @(negedge btn);
        sw      = {5'd0, op[2:0], b[3:0], a[3:0]};
        exp_alu = alu_model(a[3:0], b[3:0], alu_op_e'(op[2:0]));
    endtask

    task automatic test_reset();
        exp_alu = alu_model(4'h0, 4'h0, op_add);
        wait_bus_idle("reset");
        check_display("reset");
    endtask

    task automatic test_alu_random();
        for (int i = 0; i < 20; i++) begin
            apply_random_sw();
            wait_bus_idle($sformatf("alu %0d", i));
            check_display($sformatf("alu %0d", i));
        end
    endtask

    task automatic test_steps();
        logic [15:0] len;
        logic [15:0] gap;
        for (int i = 0; i < 12; i++) begin
            draw_bits(2, len);
            step_burst(int'(len[1:0]) + 1);
            draw_bits(2, gap);
            repeat (int'(gap[1:0])) @(negedge btn);
        end
        wait_bus_idle("steps");
        check_display("steps");
    endtask

    task automatic test_keys();
        logic [7:0] codes [3];
        codes = '{8'h1C, 8'hF0, 8'h5A};
        for (int i = 0; i < 3; i++) begin
            send_good_key(codes[i]);
            wait_bus_idle($sformatf("key %0d", i));
            check_display($sformatf("key %0d", i));
        end
    endtask

    task automatic test_bad_parity();
        send_frame(8'h33, 1'b1);
        exp_perr = 1'b1;
        wait_bus_idle("bad parity");
        check_display("bad parity");
    endtask

    // all three masters compete for the bus
    task automatic test_contention();
        fork
            send_good_key(8'h29);
            begin
                for (int i = 0; i < 12; i++) begin
                    step_burst(1 + i % 3);
                    repeat (15) @(negedge btn);
                end
            end
            begin
                for (int i = 0; i < 10; i++) begin
                    apply_random_sw();
                    repeat (22) @(negedge btn);
                end
            end
        join
        wait_bus_idle("contention");
        check_display("contention");
    endtask

    initial begin
        btn          = 1'b0;
        arst_n       = 1'b0;
        sw           = '0;
        step         = 1'b0;
        ps2_clk      = 1'b1;
        ps2_data     = 1'b1;
        rng_state    = 16'd544;
        seg_errors   = 0;
        led_errors   = 0;
        other_errors = 0;
        exp_key      = '0;
        exp_rand     = 8'h01;
        exp_alu      = '0;
        exp_count    = '0;
        exp_perr     = 1'b0;
        key_seen     = 1'b0;
        rand_seen    = 1'b0;
        repeat (4) @(negedge btn);
        arst_n = 1'b1;

        test_reset();
        test_alu_random();
        test_steps();
        test_keys();
        test_bad_parity();
        test_contention();

        $display("errors: seg %0d, leds %0d, other %0d", seg_errors, led_errors, other_errors);
        if (seg_errors + led_errors + other_errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

    initial begin
        repeat (watchdog_cycles) @(posedge btn);
        $display("watchdog: the run did not finish within %0d cycles", watchdog_cycles);
        $display(">>> FAIL");
        $finish;
    end

endmodule

/* wb_arbiter.sv */
`timescale 1ns/100ps

module wb_arbiter #(
    parameter int num_masters = 3
) (
    input  logic             btn,
    input  logic             arst_n,
    input  lab_pkg::wb_req_t m_req [num_masters],
    output lab_pkg::wb_rsp_t m_rsp [num_masters],
    output lab_pkg::wb_req_t s_req,
    input  lab_pkg::wb_rsp_t s_rsp
);

    localparam int idx_w = (num_masters > 1) ? $clog2(num_masters) : 1;

    logic [idx_w-1:0]       owner_q;
    logic                   locked_q;
    logic                   active;
    logic                   found;
    logic [idx_w-1:0]       pick;
    logic [idx_w-1:0]       sel;
    logic                   valid;
    logic [num_masters-1:0] grant;

    // owner keeps the bus until it drops cyc
    assign active = locked_q && m_req[owner_q].cyc;

    // round robin, starting after the last winner
    always_comb begin
        int idx;
        idx   = 0;
        found = 1'b0;
        pick  = owner_q;
        for (int k = 1; k <= num_masters; k++) begin
            idx = (int'(owner_q) + k) % num_masters;
            if (!found && m_req[idx].cyc) begin
                found = 1'b1;
                pick  = idx_w'(idx);
            end
        end
    end

    assign sel   = active ? owner_q : pick;
    assign valid = active || found;
    assign s_req = valid ? m_req[sel] : '0;

    always_comb begin
        for (int i = 0; i < num_masters; i++) begin
            grant[i]     = valid && (sel == idx_w'(i));
            m_rsp[i].ack = grant[i] && s_rsp.ack;
            m_rsp[i].dat = grant[i] ? s_rsp.dat : '0;
        end
    end

    always_ff @(posedge btn or negedge arst_n) begin
        if (!arst_n) begin
            owner_q  <= idx_w'(num_masters - 1);
            locked_q <= 1'b0;
        end else if (!active) begin
            locked_q <= found;
            if (found) owner_q <= pick;
        end
    end

endmodule
